/* build.f */
+incdir+tb
rtl/aes_pkg.sv
rtl/aes_key_schedule.sv
rtl/aes_key_pipeline.sv
rtl/aes_inv_round.sv
rtl/aes_decrypt_segment.sv
rtl/aes_decrypt_datapath.sv
rtl/aes_decrypt_top.sv
tb/aes_decrypt_assertions.sv
tb/aes_decrypt_tb.sv

/* rtl/aes_decrypt_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_decrypt_datapath (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 valid_in,
  input  aes_pkg::block_t      ciphertext,
  input  aes_pkg::round_keys_t keys_stage0,
  input  aes_pkg::block_t [aes_pkg::NUM_ROUNDS-aes_pkg::SEG1_LAST-1:0] keys_stage1,
  input  aes_pkg::block_t [aes_pkg::NUM_ROUNDS-aes_pkg::SEG2_LAST-1:0] keys_stage2,
  output logic                 valid_out,
  output aes_pkg::block_t      plaintext
);

  logic            valid_stage0;
  logic            valid_stage1;
  logic            valid_stage2;
  aes_pkg::block_t block_stage0;
  aes_pkg::block_t block_stage1;
  aes_pkg::block_t block_stage2;

  // Stage 0 loads at the same edge as the expanded keys
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_stage0 <= 1'b0;
      block_stage0 <= '0;
    end else begin
      valid_stage0 <= valid_in;
      block_stage0 <= ciphertext;
    end
  end

  aes_decrypt_segment #(
    .first_round (1),
    .last_round  (aes_pkg::SEG1_LAST),
    .initial_add (1'b1)
  ) segment1_inst (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_stage0),
    .state_in   (block_stage0),
    .round_keys (keys_stage0[aes_pkg::NUM_ROUNDS:aes_pkg::NUM_ROUNDS-aes_pkg::SEG1_LAST]),
    .valid_out  (valid_stage1),
    .state_out  (block_stage1)
  );

  aes_decrypt_segment #(
    .first_round (aes_pkg::SEG1_LAST + 1),
    .last_round  (aes_pkg::SEG2_LAST),
    .initial_add (1'b0)
  ) segment2_inst (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_stage1),
    .state_in   (block_stage1),
    .round_keys (keys_stage1[aes_pkg::NUM_ROUNDS-aes_pkg::SEG1_LAST-1:
                             aes_pkg::NUM_ROUNDS-aes_pkg::SEG2_LAST]),
    .valid_out  (valid_stage2),
    .state_out  (block_stage2)
  );

  // Last segment register is the output register
  aes_decrypt_segment #(
    .first_round (aes_pkg::SEG2_LAST + 1),
    .last_round  (aes_pkg::NUM_ROUNDS),
    .initial_add (1'b0)
  ) segment3_inst (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_stage2),
    .state_in   (block_stage2),
    .round_keys (keys_stage2),
    .valid_out  (valid_out),
    .state_out  (plaintext)
  );

endmodule

`default_nettype wire

/* rtl/aes_decrypt_segment.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_decrypt_segment #(
  parameter  int first_round = 1,
  parameter  int last_round  = 4,
  parameter  bit initial_add = 1'b0,
  // Round r uses key NUM_ROUNDS-r; the initial add uses key NUM_ROUNDS
  localparam int key_hi      = aes_pkg::NUM_ROUNDS - first_round + int'(initial_add),
  localparam int key_lo      = aes_pkg::NUM_ROUNDS - last_round
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 valid_in,
  input  aes_pkg::block_t                      state_in,
  input  aes_pkg::block_t [key_hi:key_lo]      round_keys,
  output logic                                 valid_out,
  output aes_pkg::block_t                      state_out
);

  aes_pkg::block_t seg_start;

  if (initial_add) begin : gen_initial_add
    assign seg_start = state_in ^ round_keys[aes_pkg::NUM_ROUNDS];
  end else begin : gen_no_add
    assign seg_start = state_in;
  end

  for (genvar r = first_round; r <= last_round; r++) begin : gen_round
    aes_pkg::block_t round_in;
    aes_pkg::block_t round_out;

    if (r == first_round) begin : gen_first
      assign round_in = seg_start;
    end else begin : gen_chain
      assign round_in = gen_round[r - 1].round_out;
    end

    // Final round skips InvMixColumns
    aes_inv_round #(
      .has_mix (r != aes_pkg::NUM_ROUNDS)
    ) aes_inv_round_inst (
      .state_in  (round_in),
      .round_key (round_keys[aes_pkg::NUM_ROUNDS - r]),
      .state_out (round_out)
    );
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      state_out <= '0;
    end else begin
      valid_out <= valid_in;
      // State holds its last block while no block arrives
      if (valid_in) begin
        state_out <= gen_round[last_round].round_out;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/aes_decrypt_top.sv */
`timescale 1ns/1ps
`default_nettype none

// AES-128 decryptor taking one block per cycle with PIPE_STAGES cycles of latency
module aes_decrypt_top (
  input  logic            clk,
  input  logic            reset,
  input  logic            valid_in,
  input  aes_pkg::block_t ciphertext,
  input  aes_pkg::block_t key,
  output logic            valid_out,
  output aes_pkg::block_t plaintext
);

  aes_pkg::round_keys_t keys_stage0;
  aes_pkg::block_t [aes_pkg::NUM_ROUNDS-aes_pkg::SEG1_LAST-1:0] keys_stage1;
  aes_pkg::block_t [aes_pkg::NUM_ROUNDS-aes_pkg::SEG2_LAST-1:0] keys_stage2;

  // Keys move down beside the data with one register per stage
  aes_key_pipeline aes_key_pipeline_inst (
    .clk         (clk),
    .reset       (reset),
    .key         (key),
    .keys_stage0 (keys_stage0),
    .keys_stage1 (keys_stage1),
    .keys_stage2 (keys_stage2)
  );

  aes_decrypt_datapath aes_decrypt_datapath_inst (
    .clk         (clk),
    .reset       (reset),
    .valid_in    (valid_in),
    .ciphertext  (ciphertext),
    .keys_stage0 (keys_stage0),
    .keys_stage1 (keys_stage1),
    .keys_stage2 (keys_stage2),
    .valid_out   (valid_out),
    .plaintext   (plaintext)
  );

endmodule

`default_nettype wire

/* rtl/aes_inv_round.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_inv_round #(
  parameter bit has_mix = 1'b1
) (
  input  aes_pkg::block_t state_in,
  input  aes_pkg::block_t round_key,
  output aes_pkg::block_t state_out
);

  aes_pkg::block_t subbed;
  aes_pkg::block_t keyed;

  // Byte n is row n%4, column n/4
  // Row r rotates right by r, so column c takes the byte from column c-r
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        subbed[127 - 8 * (4 * c + r) -: 8] =
          aes_pkg::inv_sbox(state_in[127 - 8 * (4 * ((c + 4 - r) % 4) + r) -: 8]);
      end
    end
  end

  assign keyed = subbed ^ round_key;

  if (has_mix) begin : gen_mix
    for (genvar c = 0; c < 4; c++) begin : gen_column
      assign state_out[127 - 32 * c -: 32] = aes_pkg::inv_mix_column(keyed[127 - 32 * c -: 32]);
    end
  end else begin : gen_no_mix
    assign state_out = keyed;
  end

endmodule

`default_nettype wire

/* rtl/aes_key_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_key_pipeline (
  input  logic                 clk,
  input  logic                 reset,
  input  aes_pkg::block_t      key,
  output aes_pkg::round_keys_t keys_stage0,
  output aes_pkg::block_t [aes_pkg::NUM_ROUNDS-aes_pkg::SEG1_LAST-1:0] keys_stage1,
  output aes_pkg::block_t [aes_pkg::NUM_ROUNDS-aes_pkg::SEG2_LAST-1:0] keys_stage2
);

  aes_pkg::round_keys_t expanded;

  aes_key_schedule aes_key_schedule_inst (
    .key        (key),
    .round_keys (expanded)
  );

  // Loads every cycle so each key set stays beside its block.
  // Later stages keep only the low keys that are still to be applied
  always_ff @(posedge clk) begin
    if (reset) begin
      keys_stage0 <= '0;
      keys_stage1 <= '0;
      keys_stage2 <= '0;
    end else begin
      keys_stage0 <= expanded;
      keys_stage1 <= keys_stage0[aes_pkg::NUM_ROUNDS-aes_pkg::SEG1_LAST-1:0];
      keys_stage2 <= keys_stage1[aes_pkg::NUM_ROUNDS-aes_pkg::SEG2_LAST-1:0];
    end
  end

endmodule

`default_nettype wire

/* rtl/aes_key_schedule.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_key_schedule (
  input  aes_pkg::block_t     key,
  output aes_pkg::round_keys_t round_keys
);

  localparam int NUM_WORDS = 4 * (aes_pkg::NUM_ROUNDS + 1);

  aes_pkg::word_t w [NUM_WORDS];
  aes_pkg::word_t temp;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      w[i] = key[127 - 32 * i -: 32];
    end

    for (int i = 4; i < NUM_WORDS; i++) begin
      temp = w[i - 1];
      // RotWord and SubWord together, then the round constant
      if (i % 4 == 0) begin
        temp = {aes_pkg::sbox(temp[23:16]), aes_pkg::sbox(temp[15:8]),
                aes_pkg::sbox(temp[7:0]), aes_pkg::sbox(temp[31:24])}
               ^ {aes_pkg::rcon(i / 4), 24'h0};
      end
      w[i] = w[i - 4] ^ temp;
    end

    for (int r = 0; r <= aes_pkg::NUM_ROUNDS; r++) begin
      round_keys[r] = {w[4 * r], w[4 * r + 1], w[4 * r + 2], w[4 * r + 3]};
    end
  end

endmodule

`default_nettype wire

/* rtl/aes_pkg.sv */
`default_nettype none

package aes_pkg;

  typedef logic [127:0] block_t;
  typedef logic [31:0]  word_t;
  typedef logic [7:0]   byte_t;

  localparam int NUM_ROUNDS = 10;

  // Index is the round number and 0 holds the cipher key
  typedef block_t [NUM_ROUNDS:0] round_keys_t;

  // Last inverse round of segments 1 and 2
  localparam int SEG1_LAST = 4;
  localparam int SEG2_LAST = 7;

  // Input register plus three segment registers
  localparam int PIPE_STAGES = 4;

  localparam byte_t SBOX_TABLE [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5, 8'h30, 8'h01, 8'h67, 8'h2b,
    8'hfe, 8'hd7, 8'hab, 8'h76, 8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0, 8'hb7, 8'hfd, 8'h93, 8'h26,
    8'h36, 8'h3f, 8'hf7, 8'hcc, 8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a, 8'h07, 8'h12, 8'h80, 8'he2,
    8'heb, 8'h27, 8'hb2, 8'h75, 8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84, 8'h53, 8'hd1, 8'h00, 8'hed,
    8'h20, 8'hfc, 8'hb1, 8'h5b, 8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85, 8'h45, 8'hf9, 8'h02, 8'h7f,
    8'h50, 8'h3c, 8'h9f, 8'ha8, 8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2, 8'hcd, 8'h0c, 8'h13, 8'hec,
    8'h5f, 8'h97, 8'h44, 8'h17, 8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88, 8'h46, 8'hee, 8'hb8, 8'h14,
    8'hde, 8'h5e, 8'h0b, 8'hdb, 8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79, 8'he7, 8'hc8, 8'h37, 8'h6d,
    8'h8d, 8'hd5, 8'h4e, 8'ha9, 8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6, 8'he8, 8'hdd, 8'h74, 8'h1f,
    8'h4b, 8'hbd, 8'h8b, 8'h8a, 8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e, 8'he1, 8'hf8, 8'h98, 8'h11,
    8'h69, 8'hd9, 8'h8e, 8'h94, 8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68, 8'h41, 8'h99, 8'h2d, 8'h0f,
    8'hb0, 8'h54, 8'hbb, 8'h16
  };

  localparam byte_t INV_SBOX_TABLE [256] = '{
    8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38, 8'hbf, 8'h40, 8'ha3, 8'h9e,
    8'h81, 8'hf3, 8'hd7, 8'hfb, 8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
    8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb, 8'h54, 8'h7b, 8'h94, 8'h32,
    8'ha6, 8'hc2, 8'h23, 8'h3d, 8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
    8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2, 8'h76, 8'h5b, 8'ha2, 8'h49,
    8'h6d, 8'h8b, 8'hd1, 8'h25, 8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
    8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92, 8'h6c, 8'h70, 8'h48, 8'h50,
    8'hfd, 8'hed, 8'hb9, 8'hda, 8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
    8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a, 8'hf7, 8'he4, 8'h58, 8'h05,
    8'hb8, 8'hb3, 8'h45, 8'h06, 8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
    8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b, 8'h3a, 8'h91, 8'h11, 8'h41,
    8'h4f, 8'h67, 8'hdc, 8'hea, 8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
    8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85, 8'he2, 8'hf9, 8'h37, 8'he8,
    8'h1c, 8'h75, 8'hdf, 8'h6e, 8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
    8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b, 8'hfc, 8'h56, 8'h3e, 8'h4b,
    8'hc6, 8'hd2, 8'h79, 8'h20, 8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
    8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31, 8'hb1, 8'h12, 8'h10, 8'h59,
    8'h27, 8'h80, 8'hec, 8'h5f, 8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
    8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef, 8'ha0, 8'he0, 8'h3b, 8'h4d,
    8'hae, 8'h2a, 8'hf5, 8'hb0, 8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
    8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26, 8'he1, 8'h69, 8'h14, 8'h63,
    8'h55, 8'h21, 8'h0c, 8'h7d
  };

  function automatic byte_t sbox(input byte_t b);
    return SBOX_TABLE[b];
  endfunction

  function automatic byte_t inv_sbox(input byte_t b);
    return INV_SBOX_TABLE[b];
  endfunction

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic byte_t xtime(input byte_t b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  // Multiply by a constant below 16 with one xtime per coefficient bit
  function automatic byte_t gf_mul(input byte_t b, input logic [3:0] m);
    byte_t x2;
    byte_t x4;
    byte_t x8;
    x2 = xtime(b);
    x4 = xtime(x2);
    x8 = xtime(x4);
    return ({8{m[0]}} & b) ^ ({8{m[1]}} & x2) ^ ({8{m[2]}} & x4) ^ ({8{m[3]}} & x8);
  endfunction

  function automatic word_t inv_mix_column(input word_t col);
    byte_t b [4];
    for (int i = 0; i < 4; i++) begin
      b[i] = col[31 - 8 * i -: 8];
    end
    return {gf_mul(b[0], 4'he) ^ gf_mul(b[1], 4'hb) ^ gf_mul(b[2], 4'hd) ^ gf_mul(b[3], 4'h9),
            gf_mul(b[0], 4'h9) ^ gf_mul(b[1], 4'he) ^ gf_mul(b[2], 4'hb) ^ gf_mul(b[3], 4'hd),
            gf_mul(b[0], 4'hd) ^ gf_mul(b[1], 4'h9) ^ gf_mul(b[2], 4'he) ^ gf_mul(b[3], 4'hb),
            gf_mul(b[0], 4'hb) ^ gf_mul(b[1], 4'hd) ^ gf_mul(b[2], 4'h9) ^ gf_mul(b[3], 4'he)};
  endfunction

  // Round constant for rounds 1..10 as successive powers of x
  function automatic byte_t rcon(input int round);
    byte_t r;
    r = 8'h01;
    for (int i = 1; i < NUM_ROUNDS; i++) begin
      if (i < round) begin
        r = xtime(r);
      end
    end
    return r;
  endfunction

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert -f build.f --top-module aes_decrypt_tb -o aes_decrypt_sim \
  && ./obj_dir/aes_decrypt_sim | tee /dev/stderr | grep -q "Everything OK" \
  && echo "Simulation passed" \
  || { echo "Simulation did not pass"; exit 1; }

/* tb/aes_decrypt_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_decrypt_assertions (
  input logic            clk,
  input logic            reset,
  input logic            valid_in,
  input logic            valid_out,
  input aes_pkg::block_t plaintext
);

  reset_clears_valid: assert property (@(posedge clk) reset |=> !valid_out)
    else $error("valid_out high in the cycle after reset");

  // Each strobe in comes out a fixed number of cycles later
  valid_latency: assert property (@(posedge clk) disable iff (reset)
    valid_out == $past(valid_in, aes_pkg::PIPE_STAGES))
    else $error("valid_out does not follow valid_in");

  plaintext_known: assert property (@(posedge clk) valid_out |-> !$isunknown(plaintext))
    else $error("plaintext has unknown bits while valid_out is high");

endmodule

bind aes_decrypt_top aes_decrypt_assertions aes_decrypt_assertions_inst (
  .clk       (clk),
  .reset     (reset),
  .valid_in  (valid_in),
  .valid_out (valid_out),
  .plaintext (plaintext)
);

`default_nettype wire

/* tb/aes_ref_model.svh */
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

function automatic logic [7:0] gf_multiply(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  logic [7:0] acc;
  p = 8'h00;
  acc = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      p = p ^ acc;
    end
    acc = {acc[6:0], 1'b0} ^ (acc[7] ? 8'h1b : 8'h00);
  end
  return p;
endfunction

// Field inverse followed by the affine map
function automatic logic [7:0] sub_byte(input logic [7:0] x);
  logic [7:0] inv;
  logic [7:0] sq;
  logic [7:0] s;
  inv = 8'h01;
  sq = x;
  // x^254, zero stays zero
  for (int i = 1; i < 8; i++) begin
    sq = gf_multiply(sq, sq);
    inv = gf_multiply(inv, sq);
  end
  s = inv ^ 8'h63;
  for (int k = 1; k < 5; k++) begin
    s = s ^ ((inv << k) | (inv >> (8 - k)));
  end
  return s;
endfunction

function automatic logic [127:0] encrypt_block(input logic [127:0] k, input logic [127:0] pt);
  logic [31:0]  w [44];
  logic [31:0]  t;
  logic [7:0]   rc;
  logic [7:0]   s [16];
  logic [7:0]   n [16];
  logic [127:0] ct;
  rc = 8'h01;
  for (int i = 0; i < 4; i++) begin
    w[i] = k[127 - 32 * i -: 32];
  end
  for (int i = 4; i < 44; i++) begin
    t = w[i - 1];
    if (i % 4 == 0) begin
      t = {sub_byte(t[23:16]), sub_byte(t[15:8]), sub_byte(t[7:0]), sub_byte(t[31:24])};
      t[31:24] = t[31:24] ^ rc;
      rc = gf_multiply(rc, 8'h02);
    end
    w[i] = w[i - 4] ^ t;
  end
  for (int i = 0; i < 16; i++) begin
    s[i] = pt[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
  end
  for (int round = 1; round <= 10; round++) begin
    // Byte i sits in row i%4; row r rotates left by r
    for (int i = 0; i < 16; i++) begin
      n[i] = sub_byte(s[4 * ((i / 4 + i % 4) % 4) + i % 4]);
    end
    for (int i = 0; i < 16; i++) begin
      if (round < 10) begin
        s[i] = gf_multiply(n[i], 8'h02) ^ gf_multiply(n[4 * (i / 4) + (i + 1) % 4], 8'h03)
               ^ n[4 * (i / 4) + (i + 2) % 4] ^ n[4 * (i / 4) + (i + 3) % 4];
      end else begin
        s[i] = n[i];
      end
      s[i] = s[i] ^ w[4 * round + i / 4][31 - 8 * (i % 4) -: 8];
    end
  end
  for (int i = 0; i < 16; i++) begin
    ct[127 - 8 * i -: 8] = s[i];
  end
  return ct;
endfunction

`endif

/* tb/aes_decrypt_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_decrypt_tb;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 10;
  localparam int IDLE_CYCLES    = 8;
  localparam int NUM_STREAM     = 40;
  localparam int NUM_KEY_CHANGE = 16;
  localparam int NUM_GAP_CYCLES = 60;
  localparam int NUM_MID_BLOCKS = 8;
  localparam int DRAIN_CYCLES   = aes_pkg::PIPE_STAGES + 2;
  localparam int TEST_CYCLES    = 2 * (RESET_CYCLES + IDLE_CYCLES + 2) + 3 + NUM_STREAM
                                  + NUM_KEY_CHANGE + NUM_GAP_CYCLES + NUM_MID_BLOCKS
                                  + 6 * DRAIN_CYCLES;

  logic            clk;
  logic            reset;
  logic            valid_in;
  aes_pkg::block_t ciphertext;
  aes_pkg::block_t key;
  logic            valid_out;
  aes_pkg::block_t plaintext;

  // Expected plaintexts, and the edge after which each one is due
  aes_pkg::block_t expected_q [$];
  int              due_q [$];
  int              edge_count = 0;
  int              check_count = 0;
  int              error_count = 0;
  logic            checking = 1'b0;

  `include "aes_ref_model.svh"

  aes_decrypt_top aes_decrypt_top_inst (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_in),
    .ciphertext (ciphertext),
    .key        (key),
    .valid_out  (valid_out),
    .plaintext  (plaintext)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  always @(posedge clk) begin
    edge_count <= edge_count + 1;
  end

  initial begin
    #((TEST_CYCLES + 100) * CLK_PERIOD);
    $display("Timeout: tests still running after %0d cycles", TEST_CYCLES + 100);
    $display("Something failed");
    $finish;
  end

  task automatic compare_block(input string name, input aes_pkg::block_t actual,
                               input aes_pkg::block_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_bit(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  // One scoreboard check per cycle between clock edges
  always @(negedge clk) begin
    if (checking) begin
      if (due_q.size() > 0 && due_q[0] == edge_count) begin
        compare_bit("valid_out", valid_out, 1'b1);
        compare_block("plaintext", plaintext, expected_q.pop_front());
        void'(due_q.pop_front());
      end else begin
        compare_bit("valid_out", valid_out, 1'b0);
      end
    end
  end

  function automatic aes_pkg::block_t random_block();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic drive_cycle(input logic valid, input aes_pkg::block_t k,
                             input aes_pkg::block_t ct, input aes_pkg::block_t pt);
    @(posedge clk);
    #2;
    valid_in = valid;
    key = k;
    ciphertext = ct;
    if (valid) begin
      expected_q.push_back(pt);
      due_q.push_back(edge_count + aes_pkg::PIPE_STAGES);
    end
  endtask

  task automatic send_plaintext(input aes_pkg::block_t k, input aes_pkg::block_t pt);
    drive_cycle(1'b1, k, encrypt_block(k, pt), pt);
  endtask

  task automatic drain_pipeline();
    drive_cycle(1'b0, random_block(), random_block(), '0);
    while (due_q.size() > 0) begin
      @(posedge clk);
    end
  endtask

  // Random inputs without a strobe must leave plaintext cleared
  task automatic idle_cycles(input int n);
    repeat (n) begin
      drive_cycle(1'b0, random_block(), random_block(), '0);
      @(negedge clk);
      compare_block("plaintext", plaintext, '0);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    reset = 1'b1;
    valid_in = 1'b0;
    // Blocks still inside at the reset edge never come out
    while (due_q.size() > 0 && due_q[$] > edge_count) begin
      void'(due_q.pop_back());
      void'(expected_q.pop_back());
    end
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk);
    end
    @(negedge clk);
    compare_block("plaintext", plaintext, '0);
    @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  task automatic idle_after_reset();
    apply_reset();
    idle_cycles(IDLE_CYCLES);
  endtask

  task automatic check_known_answers();
    aes_pkg::block_t keys [2];
    aes_pkg::block_t cts [2];
    aes_pkg::block_t pts [2];
    keys = '{128'h000102030405060708090a0b0c0d0e0f,
             128'h2b7e151628aed2a6abf7158809cf4f3c};
    cts  = '{128'h69c4e0d86a7b0430d8cdb78070b4c55a,
             128'h3925841d02dc09fbdc118597196a0b32};
    pts  = '{128'h00112233445566778899aabbccddeeff,
             128'h3243f6a8885a308d313198a2e0370734};
    for (int i = 0; i < 2; i++) begin
      compare_block("model ciphertext", encrypt_block(keys[i], pts[i]), cts[i]);
      drive_cycle(1'b1, keys[i], cts[i], pts[i]);
      drain_pipeline();
    end
  endtask

  task automatic stream_back_to_back();
    aes_pkg::block_t k;
    aes_pkg::block_t p;
    for (int i = 0; i < NUM_STREAM; i++) begin
      k = random_block();
      p = random_block();
      send_plaintext(k, p);
    end
    drain_pipeline();
  endtask

  task automatic alternate_keys();
    aes_pkg::block_t keys [2];
    aes_pkg::block_t p;
    keys[0] = random_block();
    keys[1] = random_block();
    p = random_block();
    // Same plaintext throughout so only the key tells neighbours apart
    for (int i = 0; i < NUM_KEY_CHANGE; i++) begin
      send_plaintext(keys[i % 2], p);
    end
    drain_pipeline();
  endtask

  task automatic send_with_gaps();
    for (int i = 0; i < NUM_GAP_CYCLES; i++) begin
      if ($urandom_range(2, 0) != 0) begin
        send_plaintext(random_block(), random_block());
      end else begin
        drive_cycle(1'b0, random_block(), random_block(), '0);
      end
    end
    drain_pipeline();
  endtask

  task automatic reset_mid_stream();
    for (int i = 0; i < NUM_MID_BLOCKS; i++) begin
      send_plaintext(random_block(), random_block());
    end
    apply_reset();
    idle_cycles(IDLE_CYCLES);
    // Pipeline accepts blocks again
    send_plaintext(random_block(), random_block());
    drain_pipeline();
  endtask

  initial begin
    reset = 1'b1;
    valid_in = 1'b0;
    key = '0;
    ciphertext = '0;
    void'($urandom(32'h02fb_4a50));
    @(posedge clk);
    checking = 1'b1;
    idle_after_reset();
    check_known_answers();
    stream_back_to_back();
    alternate_keys();
    send_with_gaps();
    reset_mid_stream();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
